//--- hw/sssp_ro_defines.svh
`ifndef SSSP_RO_DEFINES_SVH
`define SSSP_RO_DEFINES_SVH

// parent tasks in flight, as a log2
`define SSSP_THREAD_LOG 3

// outstanding memory reads, as a log2
`define SSSP_RID_LOG 3

// 64-bit edge records per memory line
`define SSSP_EDGES_PER_LINE 8

`define SSSP_LINE_BITS 512

// config write address of the neighbor base register
`define SSSP_REG_NEIGHBOR_BASE 16'h0024

`endif

//--- hw/sssp_ro_pkg.sv
`include "sssp_ro_defines.svh"

package sssp_ro_pkg;

typedef logic [31:0] ts_t;
typedef logic [31:0] vid_t;
typedef logic [31:0] eo_t;
typedef logic [31:0] addr_t;
typedef logic [`SSSP_THREAD_LOG-1:0] thread_id_t;
typedef logic [`SSSP_RID_LOG-1:0] rid_t;
typedef logic [`SSSP_EDGES_PER_LINE-1:0] edge_mask_t;
typedef logic [`SSSP_LINE_BITS-1:0] line_t;

typedef struct packed {
   ts_t  ts;
   vid_t vertex;
   eo_t  eo_begin;
   eo_t  eo_end;   // exclusive
} parent_task_t;

typedef struct packed {
   ts_t  ts;
   vid_t vertex;
} child_task_t;

// one edge record as stored in memory
typedef struct packed {
   ts_t  weight;
   vid_t neighbor;
} edge_t;

typedef struct packed {
   addr_t addr;   // line aligned
   rid_t  rid;
} ar_req_t;

typedef struct packed {
   rid_t  rid;
   line_t data;
} r_resp_t;

typedef struct packed {
   thread_id_t thread;
   edge_mask_t edge_mask;
} mshr_t;

typedef struct packed {
   logic [15:0] addr;
   logic [31:0] data;
} cfg_wr_t;

typedef struct packed {
   ts_t   ts;         // parent timestamp
   edge_t edge_rec;
   logic  last;       // last edge of the parent
} edge_item_t;

typedef enum logic {
   IDLE,
   ISSUE
} issue_state_t;

endpackage

//--- hw/free_list.sv
`timescale 1ns/1ps

module free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 push,
   input  logic [LOG_DEPTH-1:0] push_id,
   input  logic                 pop,
   output logic [LOG_DEPTH-1:0] pop_id,
   output logic                 empty,
   output logic                 all_free
);

localparam int DEPTH = 1 << LOG_DEPTH;

logic [LOG_DEPTH-1:0] ids [0:DEPTH-1];
logic [LOG_DEPTH-1:0] head;
logic [LOG_DEPTH-1:0] tail;   // wraps at DEPTH
logic [LOG_DEPTH:0]   count;

always_ff @(posedge clk) begin
   if (!rstn) begin
      // every id starts out free
      for (int i = 0; i < DEPTH; i++) begin
         ids[i] <= LOG_DEPTH'(i);
      end
      head  <= '0;
      tail  <= '0;
      count <= (LOG_DEPTH+1)'(DEPTH);
   end else begin
      if (push) begin
         ids[tail] <= push_id;
         tail      <= tail + 1'b1;
      end
      if (pop) begin
         head <= head + 1'b1;
      end
      case ({push, pop})
         2'b10:   count <= count + 1'b1;
         2'b01:   count <= count - 1'b1;
         default: count <= count;
      endcase
   end
end

assign pop_id   = ids[head];
assign empty    = (count == '0);
assign all_free = (count == (LOG_DEPTH+1)'(DEPTH));

endmodule

//--- hw/edge_read_issue.sv
`timescale 1ns/1ps
`include "sssp_ro_defines.svh"

module edge_read_issue (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      task_valid,
   output logic                      task_ready,
   input  sssp_ro_pkg::parent_task_t task_in,
   input  logic                      cfg_valid,
   input  sssp_ro_pkg::cfg_wr_t      cfg,
   output logic                      ar_valid,
   input  logic                      ar_ready,
   output sssp_ro_pkg::ar_req_t      ar,
   input  logic                      thread_avail,
   input  sssp_ro_pkg::thread_id_t   thread_id,
   output logic                      thread_alloc,
   output sssp_ro_pkg::ts_t          alloc_ts,
   output sssp_ro_pkg::eo_t          alloc_count,
   output logic                      mshr_wr_valid,
   output sssp_ro_pkg::rid_t         mshr_wr_rid,
   output sssp_ro_pkg::mshr_t        mshr_wr,
   input  logic                      rid_free_valid,
   input  sssp_ro_pkg::rid_t         rid_free
);

localparam int SLOT_W     = $clog2(`SSSP_EDGES_PER_LINE);
localparam int LINE_BYTES = `SSSP_EDGES_PER_LINE * 8;
localparam int OFS_W      = $clog2(LINE_BYTES);

sssp_ro_pkg::issue_state_t state;
sssp_ro_pkg::addr_t        base;
sssp_ro_pkg::eo_t          cur_eo;
sssp_ro_pkg::eo_t          end_eo;
sssp_ro_pkg::thread_id_t   cur_thread;

sssp_ro_pkg::addr_t        edge_addr;
sssp_ro_pkg::eo_t          remaining;
sssp_ro_pkg::edge_mask_t   line_mask;
logic [SLOT_W-1:0]         slot;
logic [SLOT_W:0]           room;
logic [SLOT_W:0]           line_cnt;
logic                      last_line;
logic                      task_empty;
logic                      task_take;
logic                      ar_fire;
logic                      rid_empty;

// neighbor base register, byte address
always_ff @(posedge clk) begin
   if (!rstn) begin
      base <= '0;
   end else if (cfg_valid && cfg.addr == `SSSP_REG_NEIGHBOR_BASE) begin
      base <= cfg.data;
   end
end

assign task_empty   = (task_in.eo_end == task_in.eo_begin);
assign task_ready   = (state == sssp_ro_pkg::IDLE) && (task_empty || thread_avail);
assign task_take    = task_valid && task_ready;
assign thread_alloc = task_take && !task_empty;   // empty tasks just drain
assign alloc_ts     = task_in.ts;
assign alloc_count  = task_in.eo_end - task_in.eo_begin;

// current line of the walk
assign edge_addr = base + {cur_eo[28:0], 3'b000};
assign slot      = edge_addr[OFS_W-1:3];
assign room      = (SLOT_W+1)'(`SSSP_EDGES_PER_LINE) - {1'b0, slot};
assign remaining = end_eo - cur_eo;
assign last_line = (remaining <= sssp_ro_pkg::eo_t'(room));
assign line_cnt  = last_line ? remaining[SLOT_W:0] : room;

always_comb begin
   for (int i = 0; i < `SSSP_EDGES_PER_LINE; i++) begin
      line_mask[i] = (i >= int'(slot)) && (i < int'(slot) + int'(line_cnt));
   end
end

assign ar_valid = (state == sssp_ro_pkg::ISSUE) && !rid_empty;
assign ar_fire  = ar_valid && ar_ready;
assign ar.addr  = edge_addr & ~sssp_ro_pkg::addr_t'(LINE_BYTES - 1);

// miss table entry goes with every accepted read
assign mshr_wr_valid    = ar_fire;
assign mshr_wr_rid      = ar.rid;
assign mshr_wr.thread    = cur_thread;
assign mshr_wr.edge_mask = line_mask;

always_ff @(posedge clk) begin
   if (!rstn) begin
      state <= sssp_ro_pkg::IDLE;
   end else begin
      case (state)
         sssp_ro_pkg::IDLE: begin
            if (thread_alloc) begin
               state <= sssp_ro_pkg::ISSUE;
            end
         end
         sssp_ro_pkg::ISSUE: begin
            if (ar_fire && last_line) begin
               state <= sssp_ro_pkg::IDLE;
            end
         end
         default: state <= sssp_ro_pkg::IDLE;
      endcase
   end
end

always_ff @(posedge clk) begin
   if (thread_alloc) begin
      cur_eo     <= task_in.eo_begin;
      end_eo     <= task_in.eo_end;
      cur_thread <= thread_id;
   end else if (ar_fire) begin
      cur_eo <= cur_eo + sssp_ro_pkg::eo_t'(line_cnt);
   end
end

free_list #(
   .LOG_DEPTH(`SSSP_RID_LOG)
) u_rid_list (
   .clk      (clk),
   .rstn     (rstn),
   .push     (rid_free_valid),
   .push_id  (rid_free),
   .pop      (ar_fire),
   .pop_id   (ar.rid),
   .empty    (rid_empty),
   .all_free ()
);

endmodule

//--- hw/line_unpack.sv
`timescale 1ns/1ps
`include "sssp_ro_defines.svh"

module line_unpack (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    mshr_wr_valid,
   input  sssp_ro_pkg::rid_t       mshr_wr_rid,
   input  sssp_ro_pkg::mshr_t      mshr_wr,
   input  logic                    r_valid,
   output logic                    r_ready,
   input  sssp_ro_pkg::r_resp_t    r,
   output logic                    rid_free_valid,
   output sssp_ro_pkg::rid_t       rid_free,
   output sssp_ro_pkg::thread_id_t lookup_thread,
   input  sssp_ro_pkg::ts_t        lookup_ts,
   output logic                    consume,
   output sssp_ro_pkg::thread_id_t consume_thread,
   input  logic                    consume_last,
   output logic                    edge_valid,
   input  logic                    edge_ready,
   output sssp_ro_pkg::edge_item_t edge_item
);

localparam int N_EDGE = `SSSP_EDGES_PER_LINE;
localparam int SEL_W  = $clog2(N_EDGE);
localparam int EDGE_W = $bits(sssp_ro_pkg::edge_t);
localparam int N_RID  = 1 << `SSSP_RID_LOG;

sssp_ro_pkg::mshr_t      mshr_tab [0:N_RID-1];

logic                    resp_valid;
sssp_ro_pkg::line_t      resp_line;
sssp_ro_pkg::edge_mask_t resp_mask;
sssp_ro_pkg::thread_id_t resp_thread;

logic [SEL_W-1:0]        sel;
sssp_ro_pkg::edge_mask_t next_mask;
logic                    r_fire;
logic                    edge_fire;

always_ff @(posedge clk) begin
   if (mshr_wr_valid) begin
      mshr_tab[mshr_wr_rid] <= mshr_wr;
   end
end

assign r_ready        = !resp_valid;
assign r_fire         = r_valid && r_ready;
assign rid_free_valid = r_fire;   // entry is copied out, rid can go back
assign rid_free       = r.rid;

// lowest pending edge slot
always_comb begin
   sel = '0;
   for (int i = N_EDGE - 1; i >= 0; i--) begin
      if (resp_mask[i]) begin
         sel = SEL_W'(i);
      end
   end
end

assign next_mask = resp_mask & ~(sssp_ro_pkg::edge_mask_t'(1) << sel);

assign edge_valid         = resp_valid;
assign edge_fire          = edge_valid && edge_ready;
assign lookup_thread      = resp_thread;
assign edge_item.ts       = lookup_ts;
assign edge_item.edge_rec = resp_line[sel*EDGE_W +: EDGE_W];
assign edge_item.last     = consume_last;

assign consume        = edge_fire;
assign consume_thread = resp_thread;

always_ff @(posedge clk) begin
   if (!rstn) begin
      resp_valid <= 1'b0;
   end else if (r_fire) begin
      resp_valid <= 1'b1;
   end else if (edge_fire && next_mask == '0) begin
      resp_valid <= 1'b0;
   end
end

always_ff @(posedge clk) begin
   if (r_fire) begin
      resp_line   <= r.data;
      resp_mask   <= mshr_tab[r.rid].edge_mask;
      resp_thread <= mshr_tab[r.rid].thread;
   end else if (edge_fire) begin
      resp_mask <= next_mask;
   end
end

endmodule

//--- hw/thread_table.sv
`timescale 1ns/1ps
`include "sssp_ro_defines.svh"

module thread_table (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    alloc,
   input  sssp_ro_pkg::ts_t        alloc_ts,
   input  sssp_ro_pkg::eo_t        alloc_count,
   output logic                    thread_avail,
   output sssp_ro_pkg::thread_id_t thread_id,
   input  sssp_ro_pkg::thread_id_t lookup_thread,
   output sssp_ro_pkg::ts_t        lookup_ts,
   input  logic                    consume,
   input  sssp_ro_pkg::thread_id_t consume_thread,
   output logic                    consume_last,
   output logic                    idle
);

localparam int N_THREAD = 1 << `SSSP_THREAD_LOG;

sssp_ro_pkg::ts_t ts_tab  [0:N_THREAD-1];
sssp_ro_pkg::eo_t cnt_tab [0:N_THREAD-1];   // edges still to emit
logic             thread_empty;

always_ff @(posedge clk) begin
   if (alloc) begin
      ts_tab[thread_id] <= alloc_ts;
   end
end

// alloc and consume never hit the same thread in one cycle
always_ff @(posedge clk) begin
   if (!rstn) begin
      for (int i = 0; i < N_THREAD; i++) begin
         cnt_tab[i] <= '0;
      end
   end else begin
      if (alloc) begin
         cnt_tab[thread_id] <= alloc_count;
      end
      if (consume) begin
         cnt_tab[consume_thread] <= cnt_tab[consume_thread] - 1'b1;
      end
   end
end

assign lookup_ts    = ts_tab[lookup_thread];
assign consume_last = (cnt_tab[consume_thread] == sssp_ro_pkg::eo_t'(1));
assign thread_avail = !thread_empty;

free_list #(
   .LOG_DEPTH(`SSSP_THREAD_LOG)
) u_thread_list (
   .clk      (clk),
   .rstn     (rstn),
   .push     (consume && consume_last),   // freed on its last edge
   .push_id  (consume_thread),
   .pop      (alloc),
   .pop_id   (thread_id),
   .empty    (thread_empty),
   .all_free (idle)
);

endmodule

//--- hw/child_gen.sv
`timescale 1ns/1ps

module child_gen (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     edge_valid,
   output logic                     edge_ready,
   input  sssp_ro_pkg::edge_item_t  edge_item,
   output logic                     child_valid,
   input  logic                     child_ready,
   output sssp_ro_pkg::child_task_t child
);

logic edge_fire;

assign edge_ready = !child_valid || child_ready;
assign edge_fire  = edge_valid && edge_ready;

always_ff @(posedge clk) begin
   if (!rstn) begin
      child_valid <= 1'b0;
   end else if (edge_fire) begin
      child_valid <= 1'b1;
   end else if (child_ready) begin
      child_valid <= 1'b0;
   end
end

// relax the edge: parent distance plus weight
always_ff @(posedge clk) begin
   if (edge_fire) begin
      child.ts     <= edge_item.ts + edge_item.edge_rec.weight;
      child.vertex <= edge_item.edge_rec.neighbor;
   end
end

endmodule

//--- hw/sssp_ro_top.sv
`timescale 1ns/1ps

module sssp_ro_top (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      task_valid,
   output logic                      task_ready,
   input  sssp_ro_pkg::parent_task_t task_in,
   output logic                      ar_valid,
   input  logic                      ar_ready,
   output sssp_ro_pkg::ar_req_t      ar,
   input  logic                      r_valid,
   output logic                      r_ready,
   input  sssp_ro_pkg::r_resp_t      r,
   output logic                      child_valid,
   input  logic                      child_ready,
   output sssp_ro_pkg::child_task_t  child,
   input  logic                      cfg_valid,
   input  sssp_ro_pkg::cfg_wr_t      cfg,
   output logic                      idle
);

logic                    thread_avail;
sssp_ro_pkg::thread_id_t thread_id;
logic                    thread_alloc;
sssp_ro_pkg::ts_t        alloc_ts;
sssp_ro_pkg::eo_t        alloc_count;
logic                    mshr_wr_valid;
sssp_ro_pkg::rid_t       mshr_wr_rid;
sssp_ro_pkg::mshr_t      mshr_wr;
logic                    rid_free_valid;
sssp_ro_pkg::rid_t       rid_free;
sssp_ro_pkg::thread_id_t lookup_thread;
sssp_ro_pkg::ts_t        lookup_ts;
logic                    consume;
sssp_ro_pkg::thread_id_t consume_thread;
logic                    consume_last;
logic                    edge_valid;
logic                    edge_ready;
sssp_ro_pkg::edge_item_t edge_item;

edge_read_issue u_issue (
   .clk            (clk),
   .rstn           (rstn),
   .task_valid     (task_valid),
   .task_ready     (task_ready),
   .task_in        (task_in),
   .cfg_valid      (cfg_valid),
   .cfg            (cfg),
   .ar_valid       (ar_valid),
   .ar_ready       (ar_ready),
   .ar             (ar),
   .thread_avail   (thread_avail),
   .thread_id      (thread_id),
   .thread_alloc   (thread_alloc),
   .alloc_ts       (alloc_ts),
   .alloc_count    (alloc_count),
   .mshr_wr_valid  (mshr_wr_valid),
   .mshr_wr_rid    (mshr_wr_rid),
   .mshr_wr        (mshr_wr),
   .rid_free_valid (rid_free_valid),
   .rid_free       (rid_free)
);

thread_table u_threads (
   .clk            (clk),
   .rstn           (rstn),
   .alloc          (thread_alloc),
   .alloc_ts       (alloc_ts),
   .alloc_count    (alloc_count),
   .thread_avail   (thread_avail),
   .thread_id      (thread_id),
   .lookup_thread  (lookup_thread),
   .lookup_ts      (lookup_ts),
   .consume        (consume),
   .consume_thread (consume_thread),
   .consume_last   (consume_last),
   .idle           (idle)
);

line_unpack u_unpack (
   .clk            (clk),
   .rstn           (rstn),
   .mshr_wr_valid  (mshr_wr_valid),
   .mshr_wr_rid    (mshr_wr_rid),
   .mshr_wr        (mshr_wr),
   .r_valid        (r_valid),
   .r_ready        (r_ready),
   .r              (r),
   .rid_free_valid (rid_free_valid),
   .rid_free       (rid_free),
   .lookup_thread  (lookup_thread),
   .lookup_ts      (lookup_ts),
   .consume        (consume),
   .consume_thread (consume_thread),
   .consume_last   (consume_last),
   .edge_valid     (edge_valid),
   .edge_ready     (edge_ready),
   .edge_item      (edge_item)
);

child_gen u_child (
   .clk         (clk),
   .rstn        (rstn),
   .edge_valid  (edge_valid),
   .edge_ready  (edge_ready),
   .edge_item   (edge_item),
   .child_valid (child_valid),
   .child_ready (child_ready),
   .child       (child)
);

endmodule

//--- verification/sssp_ro_props.sv
`timescale 1ns/1ps

module sssp_ro_props (
   input logic                      clk,
   input logic                      rstn,
   input logic                      task_valid,
   input logic                      task_ready,
   input sssp_ro_pkg::parent_task_t task_in,
   input logic                      ar_valid,
   input logic                      ar_ready,
   input sssp_ro_pkg::ar_req_t      ar,
   input logic                      r_valid,
   input logic                      r_ready,
   input logic                      child_valid,
   input logic                      child_ready,
   input sssp_ro_pkg::child_task_t  child,
   input logic                      idle
);

int fail_count = 0;

// a non-empty task takes a thread and blocks intake while its lines go out
a_task_busy: assert property (@(posedge clk) disable iff (!rstn)
   task_valid && task_ready && (task_in.eo_end != task_in.eo_begin)
   |=> !idle && !task_ready)
   else begin
      $error("non-empty task accepted without leaving idle or closing intake");
      fail_count++;
   end

// a raised valid holds with its payload until taken
a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
   ar_valid && !ar_ready |=> ar_valid && $stable(ar))
   else begin
      $error("read request dropped or changed before it was taken");
      fail_count++;
   end

// an accepted line fills the response register
a_r_taken: assert property (@(posedge clk) disable iff (!rstn)
   r_valid && r_ready |=> !r_ready)
   else begin
      $error("read response taken while the response register stayed open");
      fail_count++;
   end

a_child_hold: assert property (@(posedge clk) disable iff (!rstn)
   child_valid && !child_ready |=> child_valid && $stable(child))
   else begin
      $error("child dropped or changed before it was taken");
      fail_count++;
   end

a_reset: assert property (@(posedge clk)
   !rstn |=> !ar_valid && !child_valid && idle)
   else begin
      $error("outputs not cleared by reset");
      fail_count++;
   end

endmodule

bind sssp_ro_top sssp_ro_props u_props (.*);

//--- verification/sssp_ro_tb.sv
`timescale 1ns/1ps
`include "sssp_ro_defines.svh"

module sssp_ro_tb;

localparam int LINE_BYTES  = `SSSP_EDGES_PER_LINE * 8;
localparam int DRAIN_LIMIT = 20000;
localparam int ACCEPT_LIMIT = 1000;

logic                      clk;
logic                      rstn;
logic                      task_valid;
logic                      task_ready;
sssp_ro_pkg::parent_task_t task_in;
logic                      ar_valid;
logic                      ar_ready;
sssp_ro_pkg::ar_req_t      ar;
logic                      r_valid;
logic                      r_ready;
sssp_ro_pkg::r_resp_t      r;
logic                      child_valid;
logic                      child_ready;
sssp_ro_pkg::child_task_t  child;
logic                      cfg_valid;
sssp_ro_pkg::cfg_wr_t      cfg;
logic                      idle;

logic [31:0]        rng = 32'd13099;
sssp_ro_pkg::addr_t model_base;
int                 ready_pct;   // odds of ar_ready and child_ready, percent
int                 errors;
int                 checks;
bit                 timed_out;
bit                 task_fired;
bit                 r_fired;
int                 n_accepted;
int                 n_reads;
int                 n_children;

sssp_ro_pkg::parent_task_t task_q    [$];
sssp_ro_pkg::addr_t        exp_addr  [$];
sssp_ro_pkg::child_task_t  exp_child [$];
// reads in flight at the memory model
sssp_ro_pkg::addr_t        pool_addr  [$];
sssp_ro_pkg::rid_t         pool_rid   [$];
int                        pool_delay [$];

sssp_ro_top DUT (.*);

initial begin
   clk = 1'b0;
   forever #10 clk = ~clk;
end

function automatic logic [31:0] rand32();
   rng ^= rng << 13;
   rng ^= rng >> 17;
   rng ^= rng << 5;
   return rng;
endfunction

// memory content, a fixed function of the edge's byte address
function automatic sssp_ro_pkg::edge_t edge_at(sssp_ro_pkg::addr_t a);
   sssp_ro_pkg::edge_t e;
   e.neighbor = a * 32'h9e37_79b1 + 32'h1f;
   e.weight   = {16'h0, a[31:16] ^ a[15:0]};
   return e;
endfunction

function automatic sssp_ro_pkg::line_t line_at(sssp_ro_pkg::addr_t line_addr);
   sssp_ro_pkg::line_t l;
   for (int i = 0; i < `SSSP_EDGES_PER_LINE; i++) begin
      l[i*64 +: 64] = edge_at(line_addr + sssp_ro_pkg::addr_t'(8 * i));
   end
   return l;
endfunction

function automatic sssp_ro_pkg::parent_task_t make_task(int len);
   sssp_ro_pkg::parent_task_t t;
   t.ts       = rand32() & 32'h00ff_ffff;
   t.vertex   = rand32();
   t.eo_begin = rand32() % 4096;
   t.eo_end   = t.eo_begin + len;
   return t;
endfunction

function automatic bit busy();
   return task_q.size() > 0 || exp_addr.size() > 0 || exp_child.size() > 0 ||
          pool_addr.size() > 0 || task_valid || r_valid;
endfunction

// reference model: lines to read and children to expect for one parent
task automatic expect_task(sssp_ro_pkg::parent_task_t t);
   sssp_ro_pkg::addr_t       a;
   sssp_ro_pkg::addr_t       line;
   sssp_ro_pkg::addr_t       prev_line;
   sssp_ro_pkg::edge_t       e;
   sssp_ro_pkg::child_task_t c;
   bit                       first;
   first = 1'b1;
   for (sssp_ro_pkg::eo_t o = t.eo_begin; o != t.eo_end; o++) begin
      a    = model_base + (o << 3);
      line = a & ~sssp_ro_pkg::addr_t'(LINE_BYTES - 1);
      if (first || line != prev_line) begin
         exp_addr.push_back(line);
      end
      first     = 1'b0;
      prev_line = line;
      e         = edge_at(a);
      c.ts      = t.ts + e.weight;   // relaxed distance
      c.vertex  = e.neighbor;
      exp_child.push_back(c);
   end
endtask

task automatic check_addr(sssp_ro_pkg::addr_t got, sssp_ro_pkg::addr_t exp);
   checks++;
   if (got !== exp) begin
      $display("Fail at %0t: read address %h, expected %h", $time, got, exp);
      errors++;
   end
endtask

task automatic match_child(sssp_ro_pkg::child_task_t got);
   int idx;
   idx = -1;
   checks++;
   foreach (exp_child[i]) begin
      if (idx < 0 && exp_child[i] === got) begin
         idx = i;
      end
   end
   if (idx < 0) begin
      $display("Fail at %0t: child ts %h vertex %h matches no expected child",
               $time, got.ts, got.vertex);
      errors++;
   end else begin
      exp_child.delete(idx);
   end
endtask

task automatic verify_idle(logic got, logic exp, string when);
   checks++;
   if (got !== exp) begin
      $display("Fail at %0t: idle is %b %s, expected %b", $time, got, when, exp);
      errors++;
   end
endtask

// one clock: drive on the falling edge, then sample the transfers of the next rise
task automatic step();
   int pick;
   int n_due;
   int idx;
   @(negedge clk);
   if (task_fired) begin
      task_valid = 1'b0;
      task_fired = 1'b0;
   end
   if (r_fired) begin
      r_valid = 1'b0;
      r_fired = 1'b0;
   end
   if (!task_valid && task_q.size() > 0 && rand32() % 4 != 0) begin
      task_valid = 1'b1;
      task_in    = task_q[0];
   end
   ar_ready    = (rand32() % 100) < ready_pct;
   child_ready = (rand32() % 100) < ready_pct;
   foreach (pool_delay[i]) begin
      if (pool_delay[i] > 0) pool_delay[i]--;
   end
   if (!r_valid) begin
      n_due = 0;
      foreach (pool_delay[i]) begin
         if (pool_delay[i] == 0) n_due++;
      end
      if (n_due > 0) begin
         pick = int'(rand32() % n_due);   // any due read, so answers come out of order
         foreach (pool_delay[i]) begin
            if (pool_delay[i] == 0) begin
               if (pick == 0) begin
                  r_valid = 1'b1;
                  r.rid   = pool_rid[i];
                  r.data  = line_at(pool_addr[i]);
               end
               pick--;
            end
         end
      end
   end
   #1;
   if (task_valid && task_ready) begin
      task_fired = 1'b1;
      n_accepted++;
      expect_task(task_q.pop_front());
   end
   if (r_valid && r_ready) begin
      r_fired = 1'b1;
      idx     = -1;
      foreach (pool_rid[i]) begin
         if (pool_rid[i] == r.rid) idx = i;
      end
      pool_addr.delete(idx);
      pool_rid.delete(idx);
      pool_delay.delete(idx);
   end
   if (ar_valid && ar_ready) begin
      n_reads++;
      if (exp_addr.size() == 0) begin
         $display("read request to %h came with no read expected", ar.addr);
         errors++;
      end else begin
         check_addr(ar.addr, exp_addr.pop_front());
      end
      pool_addr.push_back(ar.addr);
      pool_rid.push_back(ar.rid);
      pool_delay.push_back(int'(rand32() % 8));
   end
   if (child_valid && child_ready) begin
      n_children++;
      match_child(child);
   end
endtask

task automatic drain(string what);
   int cyc;
   cyc = 0;
   while (busy() && cyc < DRAIN_LIMIT) begin
      step();
      cyc++;
   end
   if (busy()) begin
      $display("timeout: %s did not finish, %0d children still expected",
               what, exp_child.size());
      timed_out = 1'b1;
   end
endtask

task automatic wait_accept(int target, string what);
   int cyc;
   cyc = 0;
   while (n_accepted < target && cyc < ACCEPT_LIMIT) begin
      step();
      cyc++;
   end
   if (n_accepted < target) begin
      $display("timeout: the task of %s was never accepted", what);
      timed_out = 1'b1;
   end
endtask

task automatic write_cfg(logic [15:0] addr, logic [31:0] data);
   @(negedge clk);
   cfg_valid = 1'b1;
   cfg.addr  = addr;
   cfg.data  = data;
   if (addr == `SSSP_REG_NEIGHBOR_BASE) begin
      model_base = data;
   end
   @(negedge clk);
   cfg_valid = 1'b0;
endtask

task automatic report(string name, int mark);
   if (timed_out) begin
      $display("[%s] timed out", name);
   end else if (errors == mark) begin
      $display("[%s] ok", name);
   end else begin
      $display("[%s] %0d errors", name, errors - mark);
   end
endtask

initial begin
   int mark;
   int reads0;
   int kids0;
   rstn        = 1'b0;
   task_valid  = 1'b0;
   task_in     = '0;
   ar_ready    = 1'b0;
   r_valid     = 1'b0;
   r           = '0;
   child_ready = 1'b0;
   cfg_valid   = 1'b0;
   cfg         = '0;
   model_base  = '0;
   ready_pct   = 75;
   errors      = 0;
   checks      = 0;
   timed_out   = 1'b0;
   task_fired  = 1'b0;
   r_fired     = 1'b0;
   n_accepted  = 0;
   n_reads     = 0;
   n_children  = 0;
   repeat (5) @(posedge clk);
   @(negedge clk);
   rstn = 1'b1;

   mark = errors;
   verify_idle(idle, 1'b1, "after reset");
   report("idle_after_reset", mark);

   mark = errors;
   write_cfg(`SSSP_REG_NEIGHBOR_BASE, rand32() & 32'h0fff_fff8);
   write_cfg(16'h0028, rand32());   // other register, base stays
   for (int i = 0; i < 8; i++) begin
      task_q.push_back(make_task(1 + int'(rand32() % 24)));
   end
   drain("base_write");
   report("base_write", mark);

   if (!timed_out) begin
      mark      = errors;
      ready_pct = 90;
      for (int i = 0; i < 40; i++) begin
         task_q.push_back(make_task(1 + int'(rand32() % 40)));
      end
      drain("out_of_order");
      report("out_of_order", mark);
   end

   if (!timed_out) begin
      mark   = errors;
      reads0 = n_reads;
      kids0  = n_children;
      task_q.push_back(make_task(0));
      wait_accept(n_accepted + 1, "empty_task");
      repeat (20) step();
      checks++;
      if (n_reads != reads0 || n_children != kids0) begin
         $display("empty task produced %0d reads and %0d children",
                  n_reads - reads0, n_children - kids0);
         errors++;
      end
      verify_idle(idle, 1'b1, "after an empty task");
      report("empty_task", mark);
   end

   if (!timed_out) begin
      mark      = errors;
      ready_pct = 30;
      write_cfg(`SSSP_REG_NEIGHBOR_BASE, rand32() & 32'h0fff_fff8);
      for (int i = 0; i < 30; i++) begin
         task_q.push_back(make_task((i % 4 == 0) ? 0 : 1 + int'(rand32() % 30)));
      end
      drain("backpressure");
      report("backpressure", mark);
   end

   if (!timed_out) begin
      mark      = errors;
      ready_pct = 75;
      step();
      verify_idle(idle, 1'b1, "before the task");
      task_q.push_back(make_task(1 + int'(rand32() % 20)));
      wait_accept(n_accepted + 1, "idle_flag");
      if (!timed_out) begin
         step();
         verify_idle(idle, 1'b0, "after the task was accepted");
         drain("idle_flag");
         step();
         verify_idle(idle, 1'b1, "after all children were taken");
      end
      report("idle_flag", mark);
   end

   // quiet tail, any late read or child is an extra one
   if (!timed_out) begin
      repeat (50) step();
   end

   errors += DUT.u_props.fail_count;
   $display("checks %0d, errors %0d, reads %0d, children %0d",
            checks, errors, n_reads, n_children);
   if (errors == 0 && !timed_out) begin
      $display("test passed");
   end else begin
      $display("test failed");
   end
   $finish;
end

endmodule

//--- project.f
+incdir+hw
hw/sssp_ro_pkg.sv
hw/free_list.sv
hw/edge_read_issue.sv
hw/line_unpack.sv
hw/thread_table.sv
hw/child_gen.sv
hw/sssp_ro_top.sv
verification/sssp_ro_props.sv
verification/sssp_ro_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = sssp_ro_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = test failed
PASS_MSG  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
